// ==== hw/capture_pkg.sv ====
// ========================================
// Shared widths, types and FSM states for
// the triggered capture buffer
// ========================================
`default_nettype none

package capture_pkg;

    // Memory geometry, one window fills the whole RAM
    localparam int addr_width    = 6;
    localparam int capture_depth = 2 ** addr_width;

    // Field widths of a sample beat
    localparam int data_width = 32;
    localparam int dest_width = 8;
    localparam int user_width = 8;

    typedef logic [addr_width-1:0] buf_addr_t;

    // One extra bit so a full window of capture_depth beats can be counted
    typedef logic [addr_width:0] beat_count_t;

    typedef logic [data_width-1:0] sample_data_t;
    typedef logic [dest_width-1:0] dest_t;
    typedef logic [user_width-1:0] user_t;

    // Payload stored in the RAM and carried on both streams
    typedef struct packed {
        sample_data_t data;
        dest_t        dest;
        user_t        user;
    } stream_beat_t;

    typedef struct packed {
        stream_beat_t beat;
        logic         last;
    } stream_out_t;

    typedef enum logic [2:0] {
        cap_idle,
        cap_prefill,
        cap_armed,
        cap_postfill,
        cap_readout
    } capture_state_t;

endpackage

`default_nettype wire

// ==== hw/sample_ram.sv ====
// ========================================
// Dual-port beat memory with one-cycle
// registered read
// ========================================
`default_nettype none

module sample_ram (
    input  logic                      clock,
    input  logic                      wr_en,
    input  capture_pkg::buf_addr_t    wr_addr,
    input  capture_pkg::stream_beat_t wr_beat,
    input  logic                      rd_en,
    input  capture_pkg::buf_addr_t    rd_addr,
    output capture_pkg::stream_beat_t rd_beat
);

    import capture_pkg::*;

    stream_beat_t mem [capture_depth];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Read data holds its value when no read is issued
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/capture_control.sv ====
// ========================================
// Capture FSM: writes accepted beats and
// hands the finished window to readout
// ========================================
`default_nettype none

module capture_control (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      enable,
    input  logic                      trigger,
    input  capture_pkg::buf_addr_t    trigger_point,
    input  logic                      in_valid,
    input  capture_pkg::stream_beat_t in_beat,
    output logic                      in_ready,
    output logic                      full,
    output logic                      wr_en,
    output capture_pkg::buf_addr_t    wr_addr,
    output capture_pkg::stream_beat_t wr_beat,
    output logic                      readout_start,
    output capture_pkg::buf_addr_t    window_start,
    input  logic                      readout_done
);

    import capture_pkg::*;

    capture_state_t state;
    buf_addr_t      tp_q;
    buf_addr_t      wr_ptr;
    beat_count_t    beat_cnt;
    beat_count_t    cnt_inc;
    beat_count_t    post_total;
    logic           accept;
    logic           restart;

    assign in_ready = enable && (state == cap_prefill || state == cap_armed ||
                                 state == cap_postfill);
    assign accept   = in_valid && in_ready;
    assign full     = (state == cap_readout);

    assign wr_en   = accept;
    assign wr_addr = wr_ptr;
    assign wr_beat = in_beat;

    // After the last write the pointer has wrapped onto the oldest beat
    assign window_start = wr_ptr;

    assign cnt_inc    = beat_cnt + beat_count_t'(accept);
    assign post_total = beat_count_t'(capture_depth) - beat_count_t'(tp_q);

    // A new capture begins on the first enable and after every readout
    assign restart = (state == cap_idle && enable) || (state == cap_readout && readout_done);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= cap_idle;
            tp_q          <= '0;
            wr_ptr        <= '0;
            beat_cnt      <= '0;
            readout_start <= 1'b0;
        end else begin
            readout_start <= 1'b0;
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (restart) begin
                tp_q     <= trigger_point;
                beat_cnt <= '0;
                state    <= (trigger_point == '0) ? cap_armed : cap_prefill;
            end else begin
                case (state)
                    cap_prefill: begin
                        beat_cnt <= cnt_inc;
                        if (cnt_inc == beat_count_t'(tp_q)) begin
                            state <= cap_armed;
                        end
                    end
                    cap_armed: begin
                        // The beat taken with the trigger is post-trigger beat one
                        if (trigger && enable) begin
                            beat_cnt <= beat_count_t'(accept);
                            if (beat_count_t'(accept) == post_total) begin
                                state         <= cap_readout;
                                readout_start <= 1'b1;
                            end else begin
                                state <= cap_postfill;
                            end
                        end
                    end
                    cap_postfill: begin
                        beat_cnt <= cnt_inc;
                        if (cnt_inc == post_total) begin
                            state         <= cap_readout;
                            readout_start <= 1'b1;
                        end
                    end
                    cap_idle, cap_readout: begin
                        state <= state;
                    end
                    default: begin
                        state <= cap_idle;
                    end
                endcase
            end
        end
    end

    // Every write in a counting phase stays inside the beats that phase still owes
    assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> (state == cap_prefill  ? beat_cnt < beat_count_t'(tp_q) :
                   state == cap_postfill ? beat_cnt < post_total : 1'b1));

    assert property (@(posedge clock) disable iff (!arst_n)
        readout_done |-> (state == cap_readout));

endmodule

`default_nettype wire

// ==== hw/readout_engine.sv ====
// ========================================
// Plays the captured window back, oldest
// beat first, through a two-entry queue
// ========================================
`default_nettype none

module readout_engine (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      readout_start,
    input  capture_pkg::buf_addr_t    window_start,
    output logic                      rd_en,
    output capture_pkg::buf_addr_t    rd_addr,
    input  capture_pkg::stream_beat_t rd_beat,
    output logic                      out_valid,
    output capture_pkg::stream_out_t  out_data,
    input  logic                      out_ready,
    output logic                      readout_done
);

    import capture_pkg::*;

    logic        busy;
    buf_addr_t   rd_ptr;
    beat_count_t issued;
    beat_count_t sent;
    logic        rd_pend;
    logic        rd_last_pend;
    logic        last_rd;
    logic        push;
    logic        pop;
    logic        room;
    stream_out_t q_mem [2];
    logic        q_head;
    logic        q_tail;
    logic [1:0]  q_count;

    assign pop  = out_valid && out_ready;
    assign push = rd_pend;

    // Occupancy seen by a read issued now, counting the beat already on rd_beat
    assign room = (q_count - {1'b0, pop} + {1'b0, rd_pend}) < 2'd2;

    assign rd_en   = busy && (issued != beat_count_t'(capture_depth)) && room;
    assign rd_addr = rd_ptr;
    assign last_rd = (issued == beat_count_t'(capture_depth - 1));

    assign out_valid = (q_count != 2'd0);
    assign out_data  = q_mem[q_head];

    always_ff @(posedge clock) begin
        if (push) begin
            q_mem[q_tail] <= '{beat: rd_beat, last: rd_last_pend};
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy         <= 1'b0;
            rd_ptr       <= '0;
            issued       <= '0;
            sent         <= '0;
            rd_pend      <= 1'b0;
            rd_last_pend <= 1'b0;
            q_head       <= 1'b0;
            q_tail       <= 1'b0;
            q_count      <= 2'd0;
            readout_done <= 1'b0;
        end else begin
            rd_pend      <= rd_en;
            rd_last_pend <= rd_en && last_rd;
            readout_done <= pop && out_data.last;
            if (push) begin
                q_tail <= ~q_tail;
            end
            if (pop) begin
                q_head <= ~q_head;
            end
            q_count <= q_count + {1'b0, push} - {1'b0, pop};
            if (readout_start) begin
                busy   <= 1'b1;
                rd_ptr <= window_start;
                issued <= '0;
                sent   <= '0;
            end else if (busy) begin
                if (rd_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                    issued <= issued + 1'b1;
                end
                if (pop) begin
                    sent <= sent + 1'b1;
                    if (sent == beat_count_t'(capture_depth - 1)) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

    // Read issue must leave space for every beat still coming back from the RAM
    assert property (@(posedge clock) disable iff (!arst_n)
        (push && !pop) |-> (q_count < 2'd2));

endmodule

`default_nettype wire

// ==== hw/capture_buffer.sv ====
// ========================================
// Triggered capture buffer top level
// ========================================
`default_nettype none

module capture_buffer (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      enable,
    input  logic                      trigger,
    input  capture_pkg::buf_addr_t    trigger_point,
    output logic                      full,
    input  logic                      in_valid,
    input  capture_pkg::stream_beat_t in_beat,
    output logic                      in_ready,
    output logic                      out_valid,
    output capture_pkg::stream_out_t  out_data,
    input  logic                      out_ready
);

    import capture_pkg::*;

    logic         wr_en;
    buf_addr_t    wr_addr;
    stream_beat_t wr_beat;
    logic         rd_en;
    buf_addr_t    rd_addr;
    stream_beat_t rd_beat;
    logic         readout_start;
    logic         readout_done;
    buf_addr_t    window_start;

    capture_control capture_control_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_valid      (in_valid),
        .in_beat       (in_beat),
        .in_ready      (in_ready),
        .full          (full),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_beat       (wr_beat),
        .readout_start (readout_start),
        .window_start  (window_start),
        .readout_done  (readout_done)
    );

    sample_ram sample_ram_inst (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    readout_engine readout_engine_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .readout_start (readout_start),
        .window_start  (window_start),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_beat       (rd_beat),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready),
        .readout_done  (readout_done)
    );

endmodule

`default_nettype wire

// ==== tests/capture_buffer_tb.sv ====
// ========================================
// Testbench for the triggered capture
// buffer with a reference window model
// ========================================
`default_nettype none

module capture_buffer_tb;

    import capture_pkg::*;

    typedef stream_beat_t beat_q_t[$];

    localparam int     rounds        = 8;
    localparam int     clock_period  = 40;
    localparam longint watchdog_time = (rounds * 6 * capture_depth + 200) * clock_period;

    logic         clock;
    logic         arst_n;
    logic         enable;
    logic         trigger;
    buf_addr_t    trigger_point;
    logic         full;
    logic         in_valid;
    stream_beat_t in_beat;
    logic         in_ready;
    logic         out_valid;
    stream_out_t  out_data;
    logic         out_ready;

    logic [31:0]    lfsr = 32'h4f4c;
    int             errors = 0;
    int             checks = 0;
    int             rounds_done = 0;
    int             out_idx = 0;
    beat_q_t        acc_q;
    beat_q_t        exp_q;
    capture_state_t m_state = cap_idle;
    int             m_tp;
    int             m_cnt;
    logic           accept_now;
    logic           done_pending = 1'b0;
    logic           want_trig = 1'b0;
    stream_beat_t   trig_beat;
    logic           point_set = 1'b0;

    capture_buffer capture_buffer_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .full          (full),
        .in_valid      (in_valid),
        .in_beat       (in_beat),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] value;
        value = rand_bits(1);
        return value[0];
    endfunction

    // Expected playback: the last capture_depth accepted beats, oldest first
    function automatic beat_q_t build_window(input beat_q_t accepted);
        beat_q_t win;
        int      first;
        int      i;
        first = accepted.size() - capture_depth;
        for (i = 0; i < capture_depth; i++) begin
            win.push_back(accepted[first + i]);
        end
        return win;
    endfunction

    function automatic buf_addr_t choose_point(input int round);
        logic [31:0] r;
        r = rand_bits(addr_width);
        if (round == 1) begin
            return '0;
        end else if (round == 2) begin
            return buf_addr_t'(capture_depth - 1);
        end else begin
            return r[addr_width-1:0];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        r         = rand_bits(4);
        enable    = (r[3:0] != 4'd0);
        r         = rand_bits(2);
        in_valid  = (r[1:0] != 2'd0);
        r         = rand_bits(3);
        trigger   = (r[2:0] == 3'd7);
        out_ready = rand_bit();
        in_beat.data = rand_bits(data_width);
        r            = rand_bits(dest_width + user_width);
        in_beat.dest = r[15:8];
        in_beat.user = r[7:0];
    endtask

    task automatic start_capture();
        m_tp    = int'(trigger_point);
        m_cnt   = 0;
        m_state = (m_tp == 0) ? cap_armed : cap_prefill;
    endtask

    task automatic finish_capture();
        m_state = cap_readout;
        exp_q   = build_window(acc_q);
    endtask

    // Reference model, stepped at the falling edge for the next rising edge
    always @(negedge clock) begin
        if (!arst_n) begin
            check_value("reset full", 64'(1'b0), 64'(full));
            check_value("reset in_ready", 64'(1'b0), 64'(in_ready));
            check_value("reset out_valid", 64'(1'b0), 64'(out_valid));
        end else begin
            check_value($sformatf("in_ready in %s", m_state.name()),
                        64'(enable && (m_state == cap_prefill || m_state == cap_armed ||
                                       m_state == cap_postfill)), 64'(in_ready));
            check_value($sformatf("full in %s", m_state.name()),
                        64'(m_state == cap_readout), 64'(full));
            if (out_valid && m_state != cap_readout) begin
                errors++;
                $display("Output beat offered while no window is being played back");
            end
            accept_now = in_valid && in_ready;
            if (accept_now) begin
                acc_q.push_back(in_beat);
                if (acc_q.size() > capture_depth) begin
                    void'(acc_q.pop_front());
                end
                if (want_trig) begin
                    trig_beat = in_beat;
                    want_trig = 1'b0;
                end
            end
            case (m_state)
                cap_idle: begin
                    if (enable) begin
                        start_capture();
                    end
                end
                cap_prefill: begin
                    m_cnt += int'(accept_now);
                    if (m_cnt == m_tp) begin
                        m_state = cap_armed;
                    end
                end
                cap_armed: begin
                    if (trigger && enable) begin
                        m_cnt     = int'(accept_now);
                        want_trig = !accept_now;
                        trig_beat = in_beat;
                        if (m_cnt == capture_depth - m_tp) begin
                            finish_capture();
                        end else begin
                            m_state = cap_postfill;
                        end
                    end
                end
                cap_postfill: begin
                    m_cnt += int'(accept_now);
                    if (m_cnt == capture_depth - m_tp) begin
                        finish_capture();
                    end
                end
                default: begin
                    // The done pulse follows the last transfer, then capture restarts
                    if (done_pending) begin
                        done_pending = 1'b0;
                        start_capture();
                    end else begin
                        done_pending = out_valid && out_ready && out_data.last;
                    end
                end
            endcase
        end
    end

    // Compares every transferred output beat with the expected window
    always @(negedge clock) begin
        if (arst_n && out_valid && out_ready) begin
            if (out_idx >= capture_depth) begin
                errors++;
                $display("More beats transferred than one window holds");
            end else begin
                check_value($sformatf("round %0d beat %0d", rounds_done, out_idx),
                            64'(exp_q[out_idx]), 64'(out_data.beat));
                check_value($sformatf("round %0d last %0d", rounds_done, out_idx),
                            64'(out_idx == capture_depth - 1), 64'(out_data.last));
                if (out_idx == m_tp) begin
                    check_value($sformatf("round %0d trigger position", rounds_done),
                                64'(trig_beat), 64'(out_data.beat));
                end
            end
            if (out_data.last) begin
                out_idx = 0;
                rounds_done++;
            end else begin
                out_idx++;
            end
        end
    end

    initial begin
        #(watchdog_time);
        $display("Timeout after %0d of %0d rounds", rounds_done, rounds);
        $display("Checks failed");
        $finish;
    end

    initial begin
        arst_n        = 1'b0;
        enable        = 1'b0;
        trigger       = 1'b0;
        trigger_point = '0;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_ready     = 1'b0;
        repeat (3) @(posedge clock);
        #5 arst_n = 1'b1;
        // Enable stays low for a while, so in_ready must stay low too
        repeat (2) @(posedge clock);
        #5 trigger_point = choose_point(0);
        while (rounds_done < rounds) begin
            @(posedge clock);
            #5;
            drive_cycle();
            if (full && !point_set) begin
                trigger_point = choose_point(rounds_done + 1);
                point_set     = 1'b1;
            end else if (!full) begin
                point_set = 1'b0;
            end
        end
        in_valid = 1'b0;
        trigger  = 1'b0;
        repeat (4) @(posedge clock);
        $display("Summary: %0d rounds, %0d checks, %0d errors", rounds_done, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/capture_pkg.sv
hw/sample_ram.sv
hw/capture_control.sv
hw/readout_engine.sv
hw/capture_buffer.sv
tests/capture_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run for the triggered capture buffer

VERILATOR ?= verilator
TOP       ?= capture_buffer_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^All checks passed$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
